/* sim.f */
float_format_pkg.sv
float_ops_pkg.sv
float_multiplier.sv
float_adder.sv
float_result_select.sv
float_unit.sv
float_unit_tb.sv

/* float_unit_tb.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// testbench for the float unit, random and directed
// add, subtract and multiply against a truncating model
//////////////////////////////////////////////////

module float_unit_tb
	import float_format_pkg::*;
	import float_ops_pkg::*;
;

	localparam int BITS = default_bits;
	localparam int EXP_BITS = default_exp_bits;
	localparam int MANT_BITS = BITS - EXP_BITS - 1;
	localparam int EXP_BIAS = (1 << (EXP_BITS - 1)) - 1;
	localparam longint ONE = longint'(1) << MANT_BITS;
	localparam int DONE_TIMEOUT = 50;
	localparam int DONE_LATENCY = 5;

	logic in_clk;
	logic in_rst;
	logic in_start;
	t_float_op in_op;
	logic [BITS-1:0] in_a;
	logic [BITS-1:0] in_b;
	logic [BITS-1:0] out_result;
	logic out_done;

	logic [31:0] rng_state;
	logic [BITS-1:0] expected_q[$];
	int checks;
	int value_errors;
	int other_errors;
	logic timed_out;

	float_unit #(
		.BITS(BITS),
		.EXP_BITS(EXP_BITS)
	) UUT (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.in_start(in_start),
		.in_op(in_op),
		.in_a(in_a),
		.in_b(in_b),
		.out_result(out_result),
		.out_done(out_done)
	);

	initial begin
		in_clk = 1'b0;
		forever #5 in_clk = ~in_clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// truncating float model with integer mantissas
	function automatic logic [BITS-1:0] model_result(input t_float_op op,
			input logic [BITS-1:0] a, input logic [BITS-1:0] b);
		logic sign_a;
		logic sign_b;
		logic sign_res;
		int exp_a;
		int exp_b;
		int exp_res;
		longint mant_a;
		longint mant_b;
		longint mant_big;
		longint mant_small;
		longint value;
		sign_a = a[BITS-1];
		sign_b = b[BITS-1];
		exp_a = a[BITS-2 -: EXP_BITS];
		exp_b = b[BITS-2 -: EXP_BITS];
		mant_a = ONE | a[MANT_BITS-1:0];
		mant_b = ONE | b[MANT_BITS-1:0];
		if (op == op_mul) begin
			if (exp_a == 0 || exp_b == 0)
				return '0;
			value = mant_a * mant_b;
			exp_res = exp_a + exp_b - EXP_BIAS;
			// product of two values in [1,2) may reach 2
			if (value >= 2 * ONE * ONE) begin
				value = value >> 1;
				exp_res++;
			end
			value = value >> MANT_BITS;
			return {sign_a ^ sign_b, exp_res[EXP_BITS-1:0], value[MANT_BITS-1:0]};
		end
		if (op == op_sub)
			sign_b = ~sign_b;
		if (exp_a == 0 && exp_b == 0)
			return '0;
		if (exp_a == 0)
			return {sign_b, b[BITS-2:0]};
		if (exp_b == 0)
			return a;
		if (exp_a > exp_b || (exp_a == exp_b && mant_a >= mant_b)) begin
			sign_res = sign_a;
			exp_res = exp_a;
			mant_big = mant_a;
			mant_small = mant_b >> (exp_a - exp_b);
		end else begin
			sign_res = sign_b;
			exp_res = exp_b;
			mant_big = mant_b;
			mant_small = mant_a >> (exp_b - exp_a);
		end
		value = (sign_a == sign_b) ? mant_big + mant_small : mant_big - mant_small;
		if (value == 0)
			return '0;
		if (value >= 2 * ONE) begin
			value = value >> 1;
			exp_res++;
		end
		while (value < ONE) begin
			value = value << 1;
			exp_res--;
		end
		return {sign_res, exp_res[EXP_BITS-1:0], value[MANT_BITS-1:0]};
	endfunction

	// exponent kept in 100..154 so results stay normal
	task automatic random_operand(output logic [BITS-1:0] value);
		logic sign;
		logic [EXP_BITS-1:0] exp;
		rng_state = lcg_next(rng_state);
		sign = rng_state[31];
		rng_state = lcg_next(rng_state);
		exp = EXP_BITS'(100 + (rng_state[31:16] % 55));
		rng_state = lcg_next(rng_state);
		value = {sign, exp, rng_state[31 -: MANT_BITS]};
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// one operation, optionally with a second start that must be ignored
	task automatic run_op(input t_float_op op, input logic [BITS-1:0] a,
			input logic [BITS-1:0] b, input logic [BITS-1:0] expected, input int restart_cycle);
		int cycles;
		logic got_done;
		if (!timed_out) begin
			cycles = 0;
			got_done = 1'b0;
			expected_q.push_back(expected);
			in_op = op;
			in_a = a;
			in_b = b;
			in_start = 1'b1;
			while (!got_done && cycles < DONE_TIMEOUT) begin
				@(posedge in_clk);
				#1;
				cycles++;
				in_start = (cycles == restart_cycle);
				got_done = out_done;
			end
			if (!got_done) begin
				timed_out = 1'b1;
				other_errors++;
				$display("done never came for %s started at %0t ns", op.name(),
					$time - cycles * 10);
			end else begin
				check_value("done latency", cycles, DONE_LATENCY);
				@(posedge in_clk);
				#1;
				check_value("out_done", out_done, 1'b0);
			end
		end
	endtask

	// compare each done pulse with the oldest expected result
	always @(posedge in_clk) begin
		if (!in_rst && out_done) begin
			if (expected_q.size() == 0) begin
				other_errors++;
				$display("done pulse at %0t ns with no operation in flight", $time);
			end else begin
				check_value("out_result", out_result, expected_q.pop_front());
			end
		end
	end

	initial begin
		logic [BITS-1:0] a;
		logic [BITS-1:0] b;
		in_rst = 1'b1;
		in_start = 1'b0;
		in_op = op_add;
		in_a = '0;
		in_b = '0;
		rng_state = 32'h25cc25e3;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		timed_out = 1'b0;
		repeat (4) @(posedge in_clk);
		#1;
		in_rst = 1'b0;
		@(posedge in_clk);
		#1;
		check_value("out_done", out_done, 1'b0);
		check_value("out_result", out_result, '0);

		// zero handling and simple normalisation
		run_op(op_mul, 32'h8000_1234, 32'h4049_0fdb, 32'h0000_0000, 0);
		run_op(op_mul, 32'h3fc0_0000, 32'h3fc0_0000, 32'h4010_0000, 0);
		run_op(op_add, 32'h4049_0fdb, 32'h0000_0000, 32'h4049_0fdb, 0);
		run_op(op_add, 32'h0000_0000, 32'hc049_0fdb, 32'hc049_0fdb, 0);
		run_op(op_sub, 32'h0000_0000, 32'h4049_0fdb, 32'hc049_0fdb, 0);
		run_op(op_sub, 32'h4049_0fdb, 32'h4049_0fdb, 32'h0000_0000, 0);
		run_op(op_sub, 32'hc049_0fdb, 32'hc049_0fdb, 32'h0000_0000, 0);
		run_op(op_add, 32'h3f80_0000, 32'h3f80_0000, 32'h4000_0000, 0);
		run_op(op_sub, 32'h3fc0_0000, 32'h3fa0_0000, 32'h3e80_0000, 0);
		run_op(op_add, 32'h3f80_0000, 32'h3200_0000, 32'h3f80_0000, 0);

		for (int i = 0; i < 200; i++) begin
			random_operand(a);
			random_operand(b);
			run_op(op_mul, a, b, model_result(op_mul, a, b), 0);
		end
		for (int i = 0; i < 200; i++) begin
			random_operand(a);
			random_operand(b);
			run_op(op_add, a, b, model_result(op_add, a, b), 0);
			random_operand(a);
			random_operand(b);
			run_op(op_sub, a, b, model_result(op_sub, a, b), 0);
		end

		// extra start while both engines are still busy
		random_operand(a);
		random_operand(b);
		run_op(op_mul, a, b, model_result(op_mul, a, b), 1);
		run_op(op_add, a, b, model_result(op_add, a, b), 2);

		repeat (2) @(posedge in_clk);
		if (!timed_out && expected_q.size() != 0) begin
			other_errors++;
			$display("%0d operations ended without a done pulse", expected_q.size());
		end
		$display("checks %0d, value errors %0d, other errors %0d", checks, value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* float_unit.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// float unit top, add, subtract or multiply per start
// operands and opcode stay stable until out_done
//////////////////////////////////////////////////

module float_unit
	import float_format_pkg::*;
	import float_ops_pkg::*;
#(
	parameter int BITS = default_bits,
	parameter int EXP_BITS = default_exp_bits
)
(
	input logic in_clk,
	input logic in_rst,
	input logic in_start,
	input t_float_op in_op,
	input logic [BITS-1:0] in_a,
	input logic [BITS-1:0] in_b,
	output logic [BITS-1:0] out_result,
	output logic out_done
);

	// engine results and their finished levels
	logic [BITS-1:0] mult_prod;
	logic [BITS-1:0] add_sum;
	logic mult_finished;
	logic add_finished;

	float_multiplier #(
		.BITS(BITS),
		.EXP_BITS(EXP_BITS)
	) u_mult (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.in_start(in_start),
		.in_a(in_a),
		.in_b(in_b),
		.out_prod(mult_prod),
		.out_finished(mult_finished)
	);

	// add and subtract share one engine
	float_adder #(
		.BITS(BITS),
		.EXP_BITS(EXP_BITS)
	) u_add (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.in_start(in_start),
		.in_op(in_op),
		.in_a(in_a),
		.in_b(in_b),
		.out_sum(add_sum),
		.out_finished(add_finished)
	);

	float_result_select #(
		.BITS(BITS)
	) u_select (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.in_start(in_start),
		.in_op(in_op),
		.in_prod(mult_prod),
		.in_sum(add_sum),
		.in_mult_finished(mult_finished),
		.in_add_finished(add_finished),
		.out_result(out_result),
		.out_done(out_done)
	);

endmodule

/* float_result_select.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// waits for both engines, keeps the result of the
// requested operation and pulses done for one cycle
//////////////////////////////////////////////////

module float_result_select
	import float_format_pkg::*;
	import float_ops_pkg::*;
#(
	parameter int BITS = default_bits
)
(
	input logic in_clk,
	input logic in_rst,
	input logic in_start,
	input t_float_op in_op,
	input logic [BITS-1:0] in_prod,
	input logic [BITS-1:0] in_sum,
	input logic in_mult_finished,
	input logic in_add_finished,
	output logic [BITS-1:0] out_result,
	output logic out_done
);

	// an operation is in flight
	logic pending;
	t_float_op op_q;
	logic both_finished;

	assign both_finished = pending && in_mult_finished && in_add_finished;

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			pending <= 1'b0;
			op_q <= op_add;
			out_result <= '0;
			out_done <= 1'b0;
		end else begin
			out_done <= both_finished;
			if (both_finished) begin
				pending <= 1'b0;
				out_result <= (op_q == op_mul) ? in_prod : in_sum;
			end else if (in_start && !pending) begin
				// starts while pending are dropped
				pending <= 1'b1;
				op_q <= in_op;
			end
		end
	end

	// done is a single-cycle pulse per operation
	assert property (@(posedge in_clk) disable iff (in_rst)
		out_done |=> !out_done);

endmodule

/* float_adder.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// sequential float adder and subtractor, one result per start
// aligns, adds magnitudes and renormalises, truncating throughout
//////////////////////////////////////////////////

module float_adder
	import float_format_pkg::*;
	import float_ops_pkg::*;
#(
	parameter int BITS = default_bits,
	parameter int EXP_BITS = default_exp_bits
)
(
	input logic in_clk,
	input logic in_rst,
	input logic in_start,
	input t_float_op in_op,
	input logic [BITS-1:0] in_a,
	input logic [BITS-1:0] in_b,
	output logic [BITS-1:0] out_sum,
	output logic out_finished
);

	localparam int MANT_BITS = BITS - EXP_BITS - 1;
	localparam int LZ_BITS = $clog2(MANT_BITS + 2);

	t_add_state state;
	t_add_state state_next;

	// operands, b with its sign flipped for subtract
	logic a_sign;
	logic b_sign;
	logic [EXP_BITS-1:0] a_exp;
	logic [EXP_BITS-1:0] b_exp;
	logic a_zero;
	logic b_zero;
	logic a_ge_b;

	// alignment
	logic big_sign;
	logic [EXP_BITS-1:0] big_exp;
	logic [MANT_BITS:0] big_mant;
	logic [MANT_BITS:0] small_mant;
	logic [EXP_BITS-1:0] exp_diff;
	logic [BITS-1:0] pass_value;

	// pipeline of the sequential steps
	logic sign_q;
	logic [EXP_BITS-1:0] exp_q;
	logic [MANT_BITS:0] big_q;
	logic [MANT_BITS:0] small_q;
	logic eff_sub_q;
	logic pass_q;
	logic [BITS-1:0] pass_value_q;
	logic [MANT_BITS+1:0] sum_q;

	// normalisation
	logic [LZ_BITS-1:0] lz;
	logic [MANT_BITS:0] norm_mant;
	logic [EXP_BITS-1:0] exp_inc;
	logic [EXP_BITS-1:0] exp_dec;
	logic [BITS-1:0] norm_result;

	function automatic logic [LZ_BITS-1:0] lead_zeros(input logic [MANT_BITS:0] value);
		logic [LZ_BITS-1:0] count;
		logic found;
		count = '0;
		found = 1'b0;
		for (int i = MANT_BITS; i >= 0; i--) begin
			if (value[i])
				found = 1'b1;
			else if (!found)
				count = count + 1'b1;
		end
		return count;
	endfunction

	assign a_sign = in_a[BITS-1];
	assign b_sign = in_b[BITS-1] ^ (in_op == op_sub);
	assign a_exp = in_a[BITS-2 -: EXP_BITS];
	assign b_exp = in_b[BITS-2 -: EXP_BITS];
	assign a_zero = (a_exp == '0);
	assign b_zero = (b_exp == '0);
	// exponent and fraction compare as one unsigned magnitude
	assign a_ge_b = (in_a[BITS-2:0] >= in_b[BITS-2:0]);

	always_comb begin
		big_sign = a_ge_b ? a_sign : b_sign;
		big_exp = a_ge_b ? a_exp : b_exp;
		big_mant = a_ge_b ? {1'b1, in_a[MANT_BITS-1:0]} : {1'b1, in_b[MANT_BITS-1:0]};
		small_mant = a_ge_b ? {1'b1, in_b[MANT_BITS-1:0]} : {1'b1, in_a[MANT_BITS-1:0]};
		exp_diff = a_ge_b ? (a_exp - b_exp) : (b_exp - a_exp);

		// a zero operand hands the other one straight through
		if (a_zero && b_zero)
			pass_value = '0;
		else if (a_zero)
			pass_value = {b_sign, in_b[BITS-2:0]};
		else
			pass_value = in_a;
	end

	assign lz = lead_zeros(sum_q[MANT_BITS:0]);
	assign norm_mant = sum_q[MANT_BITS:0] << lz;
	assign exp_inc = exp_q + 1'b1;
	assign exp_dec = exp_q - EXP_BITS'(lz);

	always_comb begin
		if (pass_q)
			norm_result = pass_value_q;
		else if (sum_q == '0)
			norm_result = '0;
		else if (sum_q[MANT_BITS+1])
			norm_result = {sign_q, exp_inc, sum_q[MANT_BITS:1]};
		else
			norm_result = {sign_q, exp_dec, norm_mant[MANT_BITS-1:0]};
	end

	assign out_finished = (state == add_finished);

	always_comb begin
		state_next = state;
		case (state)
			add_idle: if (in_start) state_next = add_align;
			add_align: state_next = add_sum;
			add_sum: state_next = add_norm;
			add_norm: state_next = add_finished;
			add_finished: if (in_start) state_next = add_align;
			default: state_next = add_idle;
		endcase
	end

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst)
			state <= add_idle;
		else
			state <= state_next;
	end

	always_ff @(posedge in_clk) begin
		case (state)
			add_align: begin
				sign_q <= big_sign;
				exp_q <= big_exp;
				big_q <= big_mant;
				// bits shifted out are simply lost
				small_q <= small_mant >> exp_diff;
				eff_sub_q <= a_sign ^ b_sign;
				pass_q <= a_zero || b_zero;
				pass_value_q <= pass_value;
			end
			add_sum: begin
				if (eff_sub_q)
					sum_q <= {1'b0, big_q} - {1'b0, small_q};
				else
					sum_q <= {1'b0, big_q} + {1'b0, small_q};
			end
			add_norm: out_sum <= norm_result;
			default: ;
		endcase
	end

	assert property (@(posedge in_clk) disable iff (in_rst)
		state inside {add_idle, add_align, add_sum, add_norm, add_finished});

endmodule

/* float_multiplier.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// sequential float multiplier giving one product per start
// result is truncated and held while out_finished is high
//////////////////////////////////////////////////

module float_multiplier
	import float_format_pkg::*;
	import float_ops_pkg::*;
#(
	parameter int BITS = default_bits,
	parameter int EXP_BITS = default_exp_bits
)
(
	input logic in_clk,
	input logic in_rst,
	input logic in_start,
	input logic [BITS-1:0] in_a,
	input logic [BITS-1:0] in_b,
	output logic [BITS-1:0] out_prod,
	output logic out_finished
);

	localparam int MANT_BITS = BITS - EXP_BITS - 1;
	localparam int EXP_BIAS = (1 << (EXP_BITS - 1)) - 1;
	localparam int PROD_BITS = 2 * (MANT_BITS + 1);

	t_mult_state state;
	t_mult_state state_next;

	// operand fields with the hidden one restored
	logic [EXP_BITS-1:0] a_exp;
	logic [EXP_BITS-1:0] b_exp;
	logic [MANT_BITS:0] a_mant;
	logic [MANT_BITS:0] b_mant;
	logic operand_zero;
	logic [EXP_BITS-1:0] exp_sum;

	// product registers
	logic [PROD_BITS-1:0] prod_q;
	logic [EXP_BITS-1:0] exp_q;
	logic [EXP_BITS-1:0] exp_inc;
	logic sign_q;
	logic zero_q;
	logic [BITS-1:0] norm_result;

	assign a_exp = in_a[BITS-2 -: EXP_BITS];
	assign b_exp = in_b[BITS-2 -: EXP_BITS];
	assign a_mant = {1'b1, in_a[MANT_BITS-1:0]};
	assign b_mant = {1'b1, in_b[MANT_BITS-1:0]};
	assign operand_zero = (a_exp == '0) || (b_exp == '0);
	assign exp_sum = EXP_BITS'(int'(a_exp) + int'(b_exp) - EXP_BIAS);

	assign exp_inc = exp_q + 1'b1;
	assign out_finished = (state == mult_finished);

	// product lies in [1,4) so a set top bit means one extra exponent step
	always_comb begin
		if (zero_q)
			norm_result = '0;
		else if (prod_q[PROD_BITS-1])
			norm_result = {sign_q, exp_inc, prod_q[PROD_BITS-2 -: MANT_BITS]};
		else
			norm_result = {sign_q, exp_q, prod_q[PROD_BITS-3 -: MANT_BITS]};
	end

	always_comb begin
		state_next = state;
		case (state)
			mult_idle: if (in_start) state_next = mult_mult;
			mult_mult: state_next = mult_norm;
			mult_norm: state_next = mult_finished;
			mult_finished: if (in_start) state_next = mult_mult;
			default: state_next = mult_idle;
		endcase
	end

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst)
			state <= mult_idle;
		else
			state <= state_next;
	end

	always_ff @(posedge in_clk) begin
		case (state)
			mult_mult: begin
				prod_q <= a_mant * b_mant;
				exp_q <= exp_sum;
				sign_q <= in_a[BITS-1] ^ in_b[BITS-1];
				zero_q <= operand_zero;
			end
			mult_norm: out_prod <= norm_result;
			default: ;
		endcase
	end

	// an accepted start drops the finished level until the new result is ready
	assert property (@(posedge in_clk) disable iff (in_rst)
		in_start && (state == mult_idle || state == mult_finished)
		|=> !out_finished ##1 !out_finished ##1 out_finished);

endmodule

/* float_ops_pkg.sv */
//////////////////////////////////////////////////
// opcodes of the float unit and the state encodings
// of its multiplier and adder engines
//////////////////////////////////////////////////

package float_ops_pkg;

	// operation requested with the start strobe
	typedef enum logic [1:0] {
		op_add = 2'd0,
		op_sub = 2'd1,
		op_mul = 2'd2
	} t_float_op;

	// multiplier engine
	typedef enum logic [1:0] {
		mult_idle     = 2'd0,
		mult_mult     = 2'd1,
		mult_norm     = 2'd2,
		mult_finished = 2'd3
	} t_mult_state;

	// adder engine, one extra step for operand alignment
	typedef enum logic [2:0] {
		add_idle     = 3'd0,
		add_align    = 3'd1,
		add_sum      = 3'd2,
		add_norm     = 3'd3,
		add_finished = 3'd4
	} t_add_state;

endpackage

/* float_format_pkg.sv */
//////////////////////////////////////////////////
// default float format shared by the float unit
// modules take these as parameter defaults only
//////////////////////////////////////////////////

package float_format_pkg;

	// total width of a float word
	// sign, biased exponent and mantissa fraction
	localparam int default_bits = 32;

	// exponent field width
	// the bias (2^(n-1) - 1) and the mantissa width follow from this
	localparam int default_exp_bits = 8;

endpackage
